// File: bench/dallanma_golden.txt
// stall code ps operand imm pred eq lt ltu, then care g1_ps g1_valid fall_through getir_ps tahmin
// care bits 4..0 = g1_ps g1_valid fall_through getir_ps tahmin, last two seen one cycle later
// idle after reset
0 0 0 0 0 0 0 0 0 0b 0 0 0 8 0
0 0 0 0 0 0 0 0 0 0b 0 0 0 c 0
// conditional branches
0 1 1000 2000 100 0 1 0 0 1f 2100 1 1004 2100 0
0 1 1100 2000 110 0 0 1 1 1f 1104 0 1104 2104 0
0 2 1200 2000 200 1 1 0 0 1f 1204 1 1204 1204 0
0 2 1300 2000 300 1 0 0 0 1f 2300 0 1304 1208 0
0 3 1400 2000 400 0 1 1 0 1f 2400 1 1404 2400 0
0 3 1500 2000 500 1 0 1 0 1f 2500 0 1504 2404 0
0 4 1600 2000 600 1 0 1 0 1f 1604 1 1604 1604 0
0 4 1700 2000 700 1 0 0 1 1f 2700 0 1704 1608 0
0 5 1800 2000 800 1 0 1 0 1f 1804 1 1804 1804 0
0 5 1900 2000 900 1 0 0 1 1f 2900 0 1904 1808 0
0 6 1a00 2000 a00 0 0 0 1 1f 1a04 0 1a04 180c 0
0 6 1b00 2000 b00 0 0 1 0 1f 2b00 1 1b04 2b00 0
// jumps
0 7 1c00 1c00 400 1 0 0 0 1f 2000 0 1c04 2b04 0
0 8 1d00 3001 4 0 0 0 0 1f 3004 1 1d04 3004 0
0 9 1e00 1e00 100 0 0 0 0 1f 1f00 1 1e02 1f00 0
0 a 1e02 4003 0 1 0 0 0 1f 4002 0 1e04 1f04 0
// redirect during a stall, then a plain stall
1 7 1f80 5000 0 0 0 0 0 1f 5000 1 1f84 5000 0
1 0 0 0 0 0 0 0 0 0b 0 0 0 5000 0
// training at 6008
0 7 5100 6000 8 0 0 0 0 1f 6008 1 5104 6008 0
0 0 6008 7000 0 1 1 0 0 0b 0 0 0 600c 0
0 1 6008 7000 0 1 1 0 0 1f 7000 0 600c 6010 0
0 1 6008 7000 0 1 1 0 0 1f 7000 0 600c 6014 0
0 7 5200 6000 8 0 0 0 0 1f 6008 1 5204 6008 1
0 0 0 0 0 0 0 0 0 0b 0 0 0 7000 0
0 0 0 0 0 0 0 0 0 0b 0 0 0 7004 0

// File: bench/dallanma_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dallanma_tb;

    localparam int                TABLO_SATIR   = 16;
    localparam logic [31:0]       BASLANGIC_PS  = 32'h0;
    localparam int                CLK_PERIOD    = 8;
    localparam int                FIELDS        = 15;
    localparam int                MAX_VEC       = 64;
    localparam int                TIMEOUT_SLACK = 20;

    logic        clk_i;
    logic        reset_i;
    logic        getir_durdur_i;
    logic [3:0]  islem_kod_i;
    logic [31:0] islem_ps_i;
    logic [31:0] islem_islec_i;
    logic [31:0] islem_anlik_i;
    logic        islem_atladi_i;
    logic        amb_esittir_i;
    logic        amb_kucuktur_i;
    logic        amb_kucuktur_isaretsiz_i;

    logic [31:0] g1_ps_o;
    logic        g1_ps_gecerli_o;
    logic [31:0] ps_atlamadi_o;
    logic [31:0] getir_ps_o;
    logic        tahmin_atladi_o;

    logic [31:0] golden [MAX_VEC*FIELDS];
    int          num_vec   = 0;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;

    dallanma_ust #(
        .TABLO_SATIR  (TABLO_SATIR),
        .BASLANGIC_PS (BASLANGIC_PS)
    ) dut_i (
        .clk_i                    (clk_i),
        .reset_i                  (reset_i),
        .getir_durdur_i           (getir_durdur_i),
        .islem_kod_i              (islem_kod_i),
        .islem_ps_i               (islem_ps_i),
        .islem_islec_i            (islem_islec_i),
        .islem_anlik_i            (islem_anlik_i),
        .islem_atladi_i           (islem_atladi_i),
        .amb_esittir_i            (amb_esittir_i),
        .amb_kucuktur_i           (amb_kucuktur_i),
        .amb_kucuktur_isaretsiz_i (amb_kucuktur_isaretsiz_i),
        .g1_ps_o                  (g1_ps_o),
        .g1_ps_gecerli_o          (g1_ps_gecerli_o),
        .ps_atlamadi_o            (ps_atlamadi_o),
        .getir_ps_o               (getir_ps_o),
        .tahmin_atladi_o          (tahmin_atladi_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= num_vec + TIMEOUT_SLACK) begin
            $display("timeout: the run did not end within %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus and checks
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic apply_idle();
        getir_durdur_i           = 1'b0;
        islem_kod_i              = '0;
        islem_ps_i               = '0;
        islem_islec_i            = '0;
        islem_anlik_i            = '0;
        islem_atladi_i           = 1'b0;
        amb_esittir_i            = 1'b0;
        amb_kucuktur_i           = 1'b0;
        amb_kucuktur_isaretsiz_i = 1'b0;
    endtask

    task automatic apply_vector(input int v);
        int b;
        b = v * FIELDS;
        getir_durdur_i           = golden[b][0];
        islem_kod_i              = golden[b+1][3:0];
        islem_ps_i               = golden[b+2];
        islem_islec_i            = golden[b+3];
        islem_anlik_i            = golden[b+4];
        islem_atladi_i           = golden[b+5][0];
        amb_esittir_i            = golden[b+6][0];
        amb_kucuktur_i           = golden[b+7][0];
        amb_kucuktur_isaretsiz_i = golden[b+8][0];
    endtask

    // combinational branch results of vector v
    task automatic check_branch(input int v);
        int b;
        b = v * FIELDS;
        if (golden[b+9][4]) check_value("g1_ps_o", golden[b+10], g1_ps_o);
        if (golden[b+9][3]) check_value("g1_ps_gecerli_o", golden[b+11], 32'(g1_ps_gecerli_o));
        if (golden[b+9][2]) check_value("ps_atlamadi_o", golden[b+12], ps_atlamadi_o);
    endtask

    // fetch state one cycle after vector v
    task automatic check_fetch(input int v);
        int b;
        b = v * FIELDS;
        if (golden[b+9][1]) check_value("getir_ps_o", golden[b+13], getir_ps_o);
        if (golden[b+9][0]) check_value("tahmin_atladi_o", golden[b+14], 32'(tahmin_atladi_o));
    endtask

    initial begin
        reset_i = 1'b1;
        apply_idle();
        for (int i = 0; i < MAX_VEC * FIELDS; i++) begin
            golden[i] = '1;
        end
        $readmemh("bench/dallanma_golden.txt", golden);
        while (num_vec < MAX_VEC && golden[num_vec * FIELDS] != 32'hffff_ffff) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            $display("the golden file held no test vectors");
            err_cnt++;
        end

        repeat (5) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        #(CLK_PERIOD - 2);
        check_value("getir_ps_o", BASLANGIC_PS, getir_ps_o);
        check_value("tahmin_atladi_o", 32'h0, 32'(tahmin_atladi_o));

        for (int v = 0; v <= num_vec; v++) begin
            @(posedge clk_i);
            #1;
            if (v < num_vec) begin
                apply_vector(v);
            end else begin
                apply_idle();
            end
            #(CLK_PERIOD - 2);
            if (v < num_vec) check_branch(v);
            if (v > 0) check_fetch(v - 1);
        end

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dallanma.f
hw/dallanma_pkg.sv
hw/dallanma_guncelleme_if.sv
hw/dallanma_birimi.sv
hw/dallanma_tahmincisi.sv
hw/getir_ps.sv
hw/dallanma_ust.sv
bench/dallanma_tb.sv

// File: hw/dallanma_birimi.sv
`timescale 1ns/10ps
`default_nettype none

module dallanma_birimi (
    input  wire dallanma_pkg::uop_dal_t islem_kod_i,
    input  wire dallanma_pkg::ps_t      islem_ps_i,
    input  wire dallanma_pkg::ps_t      islem_islec_i,
    input  wire dallanma_pkg::veri_t    islem_anlik_i,
    input  wire                         islem_atladi_i,

    input  wire                         amb_esittir_i,
    input  wire                         amb_kucuktur_i,
    input  wire                         amb_kucuktur_isaretsiz_i,

    output dallanma_pkg::ps_t           g1_ps_o,
    output logic                        g1_ps_gecerli_o,
    output dallanma_pkg::ps_t           ps_atlamadi_o,

    dallanma_guncelleme_if.birim        guncelleme_o
);

    logic               dal_gecerli_cmb;
    logic               atladi_cmb;
    logic               sikistirilmis_cmb;
    logic               hizala_cmb;
    logic               hatali_tahmin_cmb;

    dallanma_pkg::ps_t  hedef_ham_cmb;
    dallanma_pkg::ps_t  ps_atladi_cmb;
    dallanma_pkg::ps_t  ps_atlamadi_cmb;
    dallanma_pkg::ps_t  g1_ps_cmb;

    // ------------------------------------------------------------
    // direction decode
    // ------------------------------------------------------------
    always_comb begin
        dal_gecerli_cmb   = 1'b1;
        atladi_cmb        = 1'b0;
        sikistirilmis_cmb = 1'b0;
        hizala_cmb        = 1'b0;

        case (islem_kod_i)
            dallanma_pkg::UOP_DAL_BEQ:  atladi_cmb = amb_esittir_i;
            dallanma_pkg::UOP_DAL_BNE:  atladi_cmb = !amb_esittir_i;
            dallanma_pkg::UOP_DAL_BLT:  atladi_cmb = amb_kucuktur_i;
            dallanma_pkg::UOP_DAL_BGE:  atladi_cmb = !amb_kucuktur_i;
            dallanma_pkg::UOP_DAL_BLTU: atladi_cmb = amb_kucuktur_isaretsiz_i;
            dallanma_pkg::UOP_DAL_BGEU: atladi_cmb = !amb_kucuktur_isaretsiz_i;
            dallanma_pkg::UOP_DAL_JAL: begin
                atladi_cmb = 1'b1;
            end
            dallanma_pkg::UOP_DAL_JALR: begin
                atladi_cmb = 1'b1;
                hizala_cmb = 1'b1;
            end
            dallanma_pkg::UOP_DAL_CJAL: begin
                atladi_cmb        = 1'b1;
                sikistirilmis_cmb = 1'b1;
            end
            dallanma_pkg::UOP_DAL_CJALR: begin
                atladi_cmb        = 1'b1;
                sikistirilmis_cmb = 1'b1;
                hizala_cmb        = 1'b1;
            end
            // no branch, and any unused code
            default: begin
                dal_gecerli_cmb = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------
    // addresses
    // ------------------------------------------------------------
    // register-indirect jumps drop bit 0 of the sum
    always_comb begin
        hedef_ham_cmb = islem_islec_i + dallanma_pkg::ps_t'(islem_anlik_i);

        if (hizala_cmb) begin
            ps_atladi_cmb = {hedef_ham_cmb[dallanma_pkg::PS_BIT-1:1], 1'b0};
        end else begin
            ps_atladi_cmb = hedef_ham_cmb;
        end

        if (sikistirilmis_cmb) begin
            ps_atlamadi_cmb = islem_ps_i + dallanma_pkg::PS_ADIM_C;
        end else begin
            ps_atlamadi_cmb = islem_ps_i + dallanma_pkg::PS_ADIM;
        end

        g1_ps_cmb = atladi_cmb ? ps_atladi_cmb : ps_atlamadi_cmb;
    end

    // a misprediction is only possible on a real branch
    assign hatali_tahmin_cmb = dal_gecerli_cmb && (atladi_cmb != islem_atladi_i);

    // redirect to fetch
    assign g1_ps_o         = g1_ps_cmb;
    assign g1_ps_gecerli_o = hatali_tahmin_cmb;
    assign ps_atlamadi_o   = ps_atlamadi_cmb;

    // predictor update record
    assign guncelleme_o.guncelle      = dal_gecerli_cmb;
    assign guncelleme_o.ps            = islem_ps_i;
    assign guncelleme_o.atladi        = atladi_cmb;
    assign guncelleme_o.atlanan_adres = g1_ps_cmb;
    assign guncelleme_o.hatali_tahmin = hatali_tahmin_cmb;

endmodule

`default_nettype wire

// File: hw/dallanma_guncelleme_if.sv
`timescale 1ns/10ps
`default_nettype none

// predictor update record, one write per cycle while guncelle is high
interface dallanma_guncelleme_if;

    logic               guncelle;
    dallanma_pkg::ps_t  ps;
    logic               atladi;
    dallanma_pkg::ps_t  atlanan_adres;
    logic               hatali_tahmin;

    modport birim (
        output guncelle, ps, atladi, atlanan_adres, hatali_tahmin
    );

    modport tahminci (
        input  guncelle, ps, atladi, atlanan_adres, hatali_tahmin
    );

endinterface

`default_nettype wire

// File: hw/dallanma_pkg.sv
`default_nettype none

package dallanma_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int PS_BIT      = 32;
    localparam int VERI_BIT    = 32;
    localparam int UOP_DAL_BIT = 4;

    typedef logic [PS_BIT-1:0]      ps_t;
    typedef logic [VERI_BIT-1:0]    veri_t;
    typedef logic [UOP_DAL_BIT-1:0] uop_dal_t;
    typedef logic [1:0]             sayac_t;

    // instruction size steps, full and compressed
    localparam ps_t PS_ADIM   = 32'd4;
    localparam ps_t PS_ADIM_C = 32'd2;

    // ------------------------------------------------------------
    // branch micro-op codes
    // ------------------------------------------------------------
    localparam uop_dal_t UOP_DAL_YOK   = 4'd0;
    localparam uop_dal_t UOP_DAL_BEQ   = 4'd1;
    localparam uop_dal_t UOP_DAL_BNE   = 4'd2;
    localparam uop_dal_t UOP_DAL_BLT   = 4'd3;
    localparam uop_dal_t UOP_DAL_BGE   = 4'd4;
    localparam uop_dal_t UOP_DAL_BLTU  = 4'd5;
    localparam uop_dal_t UOP_DAL_BGEU  = 4'd6;
    localparam uop_dal_t UOP_DAL_JAL   = 4'd7;
    localparam uop_dal_t UOP_DAL_JALR  = 4'd8;
    localparam uop_dal_t UOP_DAL_CJAL  = 4'd9;
    localparam uop_dal_t UOP_DAL_CJALR = 4'd10;

    // ------------------------------------------------------------
    // 2-bit counter levels
    // ------------------------------------------------------------
    localparam sayac_t SAYAC_EN_AZ         = 2'd0;
    localparam sayac_t SAYAC_ZAYIF_ATLAMAZ = 2'd1;
    localparam sayac_t SAYAC_ATLAR_ESIK    = 2'd2;
    localparam sayac_t SAYAC_EN_COK        = 2'd3;

endpackage

`default_nettype wire

// File: hw/dallanma_tahmincisi.sv
`timescale 1ns/10ps
`default_nettype none

module dallanma_tahmincisi #(
    parameter int TABLO_SATIR = 16
) (
    input  wire                     clk_i,
    input  wire                     reset_i,

    input  wire dallanma_pkg::ps_t  getir_ps_i,
    dallanma_guncelleme_if.tahminci guncelleme_i,

    output logic                    tahmin_atladi_o,
    output dallanma_pkg::ps_t       tahmin_adres_o
);

    localparam int INDIS_BIT = $clog2(TABLO_SATIR);

    // ------------------------------------------------------------
    // table storage
    // ------------------------------------------------------------
    logic [TABLO_SATIR-1:0] gecerli_q;
    dallanma_pkg::ps_t      etiket_q [TABLO_SATIR];
    dallanma_pkg::ps_t      hedef_q  [TABLO_SATIR];
    dallanma_pkg::sayac_t   sayac_q  [TABLO_SATIR];

    logic [INDIS_BIT-1:0]   oku_indis;
    logic [INDIS_BIT-1:0]   yaz_indis;
    logic                   oku_isabet;
    logic                   yaz_isabet;

    dallanma_pkg::sayac_t   sayac_eski_cmb;
    dallanma_pkg::sayac_t   sayac_yeni_cmb;

    // word-aligned index, the low two bits are dropped
    assign oku_indis = getir_ps_i[INDIS_BIT+1:2];
    assign yaz_indis = guncelleme_i.ps[INDIS_BIT+1:2];

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------
    assign oku_isabet = gecerli_q[oku_indis] && (etiket_q[oku_indis] == getir_ps_i);

    assign tahmin_atladi_o = oku_isabet &&
                             (sayac_q[oku_indis] >= dallanma_pkg::SAYAC_ATLAR_ESIK);
    assign tahmin_adres_o  = hedef_q[oku_indis];

    // ------------------------------------------------------------
    // training
    // ------------------------------------------------------------
    assign yaz_isabet = gecerli_q[yaz_indis] && (etiket_q[yaz_indis] == guncelleme_i.ps);

    always_comb begin
        // a new branch in this slot starts from weakly not-taken
        if (yaz_isabet) begin
            sayac_eski_cmb = sayac_q[yaz_indis];
        end else begin
            sayac_eski_cmb = dallanma_pkg::SAYAC_ZAYIF_ATLAMAZ;
        end

        if (guncelleme_i.atladi) begin
            if (sayac_eski_cmb == dallanma_pkg::SAYAC_EN_COK) begin
                sayac_yeni_cmb = sayac_eski_cmb;
            end else begin
                sayac_yeni_cmb = sayac_eski_cmb + 2'd1;
            end
        end else begin
            if (sayac_eski_cmb == dallanma_pkg::SAYAC_EN_AZ) begin
                sayac_yeni_cmb = sayac_eski_cmb;
            end else begin
                sayac_yeni_cmb = sayac_eski_cmb - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gecerli_q <= '0;
            for (int i = 0; i < TABLO_SATIR; i++) begin
                sayac_q[i] <= dallanma_pkg::SAYAC_ZAYIF_ATLAMAZ;
            end
        end else if (guncelleme_i.guncelle) begin
            gecerli_q[yaz_indis] <= 1'b1;
            sayac_q[yaz_indis]   <= sayac_yeni_cmb;
        end
    end

    always_ff @(posedge clk_i) begin
        if (guncelleme_i.guncelle) begin
            etiket_q[yaz_indis] <= guncelleme_i.ps;
            // not-taken resolutions keep the old target
            if (guncelleme_i.atladi) begin
                hedef_q[yaz_indis] <= guncelleme_i.atlanan_adres;
            end
        end
    end

    // ------------------------------------------------------------
    // checks on the record from the branch unit
    // ------------------------------------------------------------
    hedef_hizali_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        guncelleme_i.guncelle |-> !guncelleme_i.atlanan_adres[0]
    );

endmodule

`default_nettype wire

// File: hw/dallanma_ust.sv
`timescale 1ns/10ps
`default_nettype none

module dallanma_ust #(
    parameter int                TABLO_SATIR  = 16,
    parameter dallanma_pkg::ps_t BASLANGIC_PS = '0
) (
    input  wire                         clk_i,
    input  wire                         reset_i,
    input  wire                         getir_durdur_i,

    // resolved micro-op and compare flags
    input  wire dallanma_pkg::uop_dal_t islem_kod_i,
    input  wire dallanma_pkg::ps_t      islem_ps_i,
    input  wire dallanma_pkg::ps_t      islem_islec_i,
    input  wire dallanma_pkg::veri_t    islem_anlik_i,
    input  wire                         islem_atladi_i,
    input  wire                         amb_esittir_i,
    input  wire                         amb_kucuktur_i,
    input  wire                         amb_kucuktur_isaretsiz_i,

    output dallanma_pkg::ps_t           g1_ps_o,
    output logic                        g1_ps_gecerli_o,
    output dallanma_pkg::ps_t           ps_atlamadi_o,
    output dallanma_pkg::ps_t           getir_ps_o,
    output logic                        tahmin_atladi_o
);

    dallanma_pkg::ps_t tahmin_adres;

    dallanma_guncelleme_if guncelleme_if_i ();

    // ------------------------------------------------------------
    // branch resolution
    // ------------------------------------------------------------
    dallanma_birimi dallanma_birimi_i (
        .islem_kod_i              (islem_kod_i),
        .islem_ps_i               (islem_ps_i),
        .islem_islec_i            (islem_islec_i),
        .islem_anlik_i            (islem_anlik_i),
        .islem_atladi_i           (islem_atladi_i),
        .amb_esittir_i            (amb_esittir_i),
        .amb_kucuktur_i           (amb_kucuktur_i),
        .amb_kucuktur_isaretsiz_i (amb_kucuktur_isaretsiz_i),
        .g1_ps_o                  (g1_ps_o),
        .g1_ps_gecerli_o          (g1_ps_gecerli_o),
        .ps_atlamadi_o            (ps_atlamadi_o),
        .guncelleme_o             (guncelleme_if_i.birim)
    );

    // ------------------------------------------------------------
    // predictor and fetch address
    // ------------------------------------------------------------
    dallanma_tahmincisi #(
        .TABLO_SATIR (TABLO_SATIR)
    ) dallanma_tahmincisi_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .getir_ps_i      (getir_ps_o),
        .guncelleme_i    (guncelleme_if_i.tahminci),
        .tahmin_atladi_o (tahmin_atladi_o),
        .tahmin_adres_o  (tahmin_adres)
    );

    getir_ps #(
        .BASLANGIC_PS (BASLANGIC_PS)
    ) getir_ps_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .getir_durdur_i  (getir_durdur_i),
        .g1_ps_i         (g1_ps_o),
        .g1_ps_gecerli_i (g1_ps_gecerli_o),
        .tahmin_atladi_i (tahmin_atladi_o),
        .tahmin_adres_i  (tahmin_adres),
        .getir_ps_o      (getir_ps_o)
    );

endmodule

`default_nettype wire

// File: hw/getir_ps.sv
`timescale 1ns/10ps
`default_nettype none

module getir_ps #(
    parameter dallanma_pkg::ps_t BASLANGIC_PS = '0
) (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire                     getir_durdur_i,

    input  wire dallanma_pkg::ps_t  g1_ps_i,
    input  wire                     g1_ps_gecerli_i,

    input  wire                     tahmin_atladi_i,
    input  wire dallanma_pkg::ps_t  tahmin_adres_i,

    output dallanma_pkg::ps_t       getir_ps_o
);

    dallanma_pkg::ps_t getir_ps_q;
    dallanma_pkg::ps_t getir_ps_sonraki;

    // ------------------------------------------------------------
    // next fetch address
    // ------------------------------------------------------------
    // a redirect wins even over a stall
    always_comb begin
        if (g1_ps_gecerli_i) begin
            getir_ps_sonraki = g1_ps_i;
        end else if (getir_durdur_i) begin
            getir_ps_sonraki = getir_ps_q;
        end else if (tahmin_atladi_i) begin
            getir_ps_sonraki = tahmin_adres_i;
        end else begin
            getir_ps_sonraki = getir_ps_q + dallanma_pkg::PS_ADIM;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            getir_ps_q <= BASLANGIC_PS;
        end else begin
            getir_ps_q <= getir_ps_sonraki;
        end
    end

    assign getir_ps_o = getir_ps_q;

    // redirect lands on the fetch address one cycle later
    yonlendirme_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        g1_ps_gecerli_i |=> (getir_ps_o == $past(g1_ps_i))
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch resolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=dallanma_tb
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" \
    -f dallanma.f -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0
